// File: Makefile
# Verilator build and run of the scan doubler testbench

TOP := tb_scan2x

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: line_buffer.sv
/*
 * Two-line video buffer, one write port and one read port on clk.
 * The top address bit selects the line half. Read data is
 * registered, so it appears one clk cycle after the address.
 */
`timescale 1ns/100ps

module line_buffer (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic [video_pkg::line_aw:0] wr_addr,
    input  video_pkg::pixel_t          wr_data,
    input  logic [video_pkg::line_aw:0] rd_addr,
    output video_pkg::pixel_t          rd_data
);

    import video_pkg::*;

    // two halves of 2**line_aw pixels each
    localparam int depth = 2 ** (line_aw + 1);

    pixel_t mem [0:depth-1];

    // write side, paced by pxl_cen in the doubler
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read side runs every cycle
    // same address as a write gives the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: scan2x_top.sv
/*
 * Scan doubler top level.
 * Joins the Wishbone register block to the doubler core. Video comes
 * in on pxl_cen with hs and leaves on pxl2_cen with x2_hs.
 */
`timescale 1ns/100ps

module scan2x_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  logic                   pxl2_cen,
    input  video_pkg::pixel_t      base_pxl,
    input  logic                   hs,
    output video_pkg::pixel_t      x2_pxl,
    output logic                   x2_hs,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  scan_csr_pkg::wb_addr_t wb_adr,
    input  scan_csr_pkg::wb_data_t wb_dat_w,
    input  logic [3:0]             wb_sel,
    output scan_csr_pkg::wb_data_t wb_dat_r,
    output logic                   wb_ack
);

    import video_pkg::*;

    // mode fields toward the video path
    sl_mode_e   sl_mode;
    hz_mode_e   hz_mode;
    // measured length back to the bus
    line_addr_t line_len;

    scan_csr i_scan_csr (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .line_len (line_len),
        .sl_mode  (sl_mode),
        .hz_mode  (hz_mode)
    );

    scan_doubler i_scan_doubler (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .base_pxl (base_pxl),
        .hs       (hs),
        .sl_mode  (sl_mode),
        .hz_mode  (hz_mode),
        .x2_pxl   (x2_pxl),
        .x2_hs    (x2_hs),
        .line_len (line_len)
    );

endmodule

// File: scan_csr.sv
/*
 * Wishbone classic slave for the scan doubler.
 * Holds the scan line and blend modes and returns the measured
 * line length. Each request is acknowledged one cycle later.
 */
`timescale 1ns/100ps

module scan_csr (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  scan_csr_pkg::wb_addr_t wb_adr,
    input  scan_csr_pkg::wb_data_t wb_dat_w,
    input  logic [3:0]             wb_sel,
    output scan_csr_pkg::wb_data_t wb_dat_r,
    output logic                   wb_ack,
    input  video_pkg::line_addr_t  line_len,
    output video_pkg::sl_mode_e    sl_mode,
    output video_pkg::hz_mode_e    hz_mode
);

    import video_pkg::*;
    import scan_csr_pkg::*;

    // new request, not the cycle that acks the last one
    logic     req;
    logic     ctrl_wr;
    wb_data_t rd_word;

    assign req     = wb_cyc & wb_stb & ~wb_ack;
    // only byte lane 0 holds control bits
    assign ctrl_wr = req & wb_we & wb_sel[0] & (wb_adr == csr_ctrl_addr);

    // read mux, unmapped words are zero
    always_comb begin
        rd_word = '0;
        case (wb_adr)
            csr_ctrl_addr: begin
                rd_word[ctrl_sl_lsb +: 2] = sl_mode;
                rd_word[ctrl_hz_lsb +: 2] = hz_mode;
            end
            csr_hlen_addr: rd_word[line_aw-1:0] = line_len;
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack  <= 1'b0;
            sl_mode <= sl_mode_e'(ctrl_reset_value[ctrl_sl_lsb +: 2]);
            hz_mode <= hz_mode_e'(ctrl_reset_value[ctrl_hz_lsb +: 2]);
        end else begin
            // one cycle pulse, drops even with stb held
            wb_ack <= req;
            if (ctrl_wr) begin
                sl_mode <= sl_mode_e'(wb_dat_w[ctrl_sl_lsb +: 2]);
                hz_mode <= hz_mode_e'(wb_dat_w[ctrl_hz_lsb +: 2]);
            end
        end
    end

    // read data lines up with the ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

// File: scan_csr_pkg.sv
/*
 * Register map of the scan doubler Wishbone slave.
 * Word addresses, field positions and reset value of the
 * control register, plus the bus vector types.
 */
package scan_csr_pkg;

    // word addressed
    localparam int wb_addr_w = 4;

    typedef logic [31:0]          wb_data_t;
    typedef logic [wb_addr_w-1:0] wb_addr_t;

    // control register, sl_mode and hz_mode
    localparam wb_addr_t csr_ctrl_addr = 4'd0;
    // measured line length, read only
    localparam wb_addr_t csr_hlen_addr = 4'd1;

    // field positions inside the control word
    localparam int ctrl_sl_lsb = 0;
    localparam int ctrl_hz_lsb = 2;

    // both modes off
    localparam wb_data_t ctrl_reset_value = 32'd0;

endpackage

// File: scan_doubler.sv
/*
 * Line-rate scan doubler core.
 * Writes each input line into one half of the line buffer at the
 * pxl_cen rate and reads the other half twice at the pxl2_cen rate.
 * Regenerates the output hsync and measures the input line length.
 */
`timescale 1ns/100ps

module scan_doubler (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic                  pxl2_cen,
    input  video_pkg::pixel_t     base_pxl,
    input  logic                  hs,
    input  video_pkg::sl_mode_e   sl_mode,
    input  video_pkg::hz_mode_e   hz_mode,
    output video_pkg::pixel_t     x2_pxl,
    output logic                  x2_hs,
    output video_pkg::line_addr_t line_len
);

    import video_pkg::*;

    // half being read, the other half is written
    logic         rd_half;
    logic         last_hs;
    logic         hs_rise;
    logic         hs_fall;
    logic         scanline;
    line_addr_t   wr_cnt;
    line_addr_t   rd_cnt;
    line_addr_t   rd_next;
    line_addr_t   hs_width;
    // write position, already cleared on an hs rising edge
    line_addr_t   wr_ptr;
    logic         wr_half;
    pixel_t       rd_data;

    // hs is only looked at on pxl2_cen
    assign hs_rise = pxl2_cen & hs & ~last_hs;
    assign hs_fall = pxl2_cen & ~hs & last_hs;

    // a pixel that comes with the hs edge opens the new line
    assign wr_ptr  = hs_rise ? '0 : wr_cnt;
    assign wr_half = hs_rise ? rd_half : ~rd_half;
    assign rd_next = rd_cnt + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_hs  <= 1'b0;
            wr_cnt   <= '0;
            hs_width <= '0;
        end else begin
            if (pxl2_cen) begin
                last_hs <= hs;
            end
            if (hs_rise || pxl_cen) begin
                wr_cnt <= wr_ptr + line_addr_t'(pxl_cen);
            end
            // sync width in input pixels
            if (hs_fall) begin
                hs_width <= wr_cnt;
            end
        end
    end

    // read side, two output lines per input line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_half  <= 1'b0;
            rd_cnt   <= '0;
            line_len <= '0;
            scanline <= 1'b0;
            x2_hs    <= 1'b0;
        end else if (hs_rise) begin
            // finished line becomes the read half
            rd_half  <= ~rd_half;
            rd_cnt   <= '0;
            line_len <= wr_cnt;
            scanline <= 1'b0;
            x2_hs    <= 1'b1;
        end else if (pxl2_cen) begin
            if (rd_next == line_len) begin
                // start of the second copy
                rd_cnt   <= '0;
                scanline <= 1'b1;
                x2_hs    <= 1'b1;
            end else begin
                rd_cnt <= rd_next;
                if (rd_next == hs_width) begin
                    x2_hs <= 1'b0;
                end
            end
        end
    end

    line_buffer i_line_buffer (
        .clk     (clk),
        .wr_en   (pxl_cen),
        .wr_addr ({wr_half, wr_ptr}),
        .wr_data (base_pxl),
        .rd_addr ({rd_half, rd_cnt}),
        .rd_data (rd_data)
    );

    // rd_cnt still holds the position while the shade stage samples it
    scan_shade i_scan_shade (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl2_cen   (pxl2_cen),
        .rd_data    (rd_data),
        .line_start (rd_cnt == '0),
        .scanline   (scanline),
        .sl_mode    (sl_mode),
        .hz_mode    (hz_mode),
        .x2_pxl     (x2_pxl)
    );

endmodule

// File: scan_shade.sv
/*
 * Output pixel shading for the scan doubler.
 * Blends or blanks each buffer pixel horizontally, then dims the
 * second copy of a line by sl_mode. The result in x2_pxl holds
 * from three clk cycles after the read pxl2_cen to the next one.
 */
`timescale 1ns/100ps

module scan_shade (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pxl2_cen,
    input  video_pkg::pixel_t   rd_data,
    input  logic                line_start,
    input  logic                scanline,
    input  video_pkg::sl_mode_e sl_mode,
    input  video_pkg::hz_mode_e hz_mode,
    output video_pkg::pixel_t   x2_pxl
);

    import video_pkg::*;

    // pxl2_cen delayed by one, two and three clk cycles
    logic [2:0] cen_sr;
    // last raw pixel of the current line
    pixel_t     prev_pxl;
    // horizontal stage result
    pixel_t     hz_pxl;
    pixel_t     prev_sel;

    // per channel floor of (a + b) / 2
    function automatic pixel_t avg_px(pixel_t a, pixel_t b);
        pixel_t             res;
        color_t             ca;
        color_t             cb;
        logic [color_w:0]   sum;
        for (int c = 0; c < color_n; c++) begin
            ca = a[c*color_w +: color_w];
            cb = b[c*color_w +: color_w];
            sum = {1'b0, ca} + {1'b0, cb};
            res[c*color_w +: color_w] = sum[color_w:1];
        end
        return res;
    endfunction

    // per channel right shift, keeps channels apart
    function automatic pixel_t dim_px(pixel_t p, int shift);
        pixel_t res;
        color_t ch;
        for (int c = 0; c < color_n; c++) begin
            ch = p[c*color_w +: color_w];
            res[c*color_w +: color_w] = ch >> shift;
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_sr <= 3'b000;
        end else begin
            cen_sr <= {cen_sr[1:0], pxl2_cen};
        end
    end

    // first pixel of a line blends with black
    assign prev_sel = line_start ? '0 : prev_pxl;

    // read data is valid two cycles after pxl2_cen
    always_ff @(posedge clk) begin
        if (cen_sr[1]) begin
            prev_pxl <= rd_data;
            case (hz_mode)
                hz_blend: hz_pxl <= avg_px(rd_data, prev_sel);
                hz_blank: hz_pxl <= '0;
                // hz_off and the spare code
                default:  hz_pxl <= rd_data;
            endcase
        end
    end

    // scan line dimming, one cycle after the horizontal stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x2_pxl <= '0;
        end else if (cen_sr[2]) begin
            if (!scanline) begin
                x2_pxl <= hz_pxl;
            end else begin
                case (sl_mode)
                    sl_dim2:  x2_pxl <= dim_px(hz_pxl, 1);
                    sl_dim4:  x2_pxl <= dim_px(hz_pxl, 2);
                    sl_black: x2_pxl <= '0;
                    default:  x2_pxl <= hz_pxl;
                endcase
            end
        end
    end

endmodule

// File: tb_scan2x.sv
/*
 * Directed testbench for the scan doubler top level.
 * Generates clk and the two pixel enables, programs the modes over
 * Wishbone, sends random video lines and checks both output copies,
 * the regenerated hsync and the measured line length.
 */
`timescale 1ns/100ps

module tb_scan2x;

    import video_pkg::*;
    import scan_csr_pkg::*;

    // pixels sent over the whole run including the priming and trailing lines
    localparam int total_px = 4 * 40 + 3 * 3 * 24 + 2 * 3 * 32 + 3 * 50;
    // 64 ns per input pixel with a factor of two and room for reset and bus time
    localparam int watchdog_ns = total_px * 64 * 2 + 20000;

    logic       clk;
    logic       rst_n;
    logic       pxl_cen;
    logic       pxl2_cen;
    pixel_t     base_pxl;
    logic       hs;
    pixel_t     x2_pxl;
    logic       x2_hs;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    wb_data_t   wb_dat_w;
    logic [3:0] wb_sel;
    wb_data_t   wb_dat_r;
    logic       wb_ack;

    // free running cycle count that sets the enable phase
    int         cyc = 0;
    int         seed;
    // reference lines indexed by line number modulo 4
    pixel_t     ref_pix [0:3][0:511];
    int         mode_sl;
    int         mode_hz;
    // output monitor samples taken once per pxl2_cen
    pixel_t     smp_pxl;
    logic       smp_hs;
    logic       smp_rise;
    event       sample_ev;
    string      cur_test;
    int         err_cnt;
    int         chk_cnt;
    int         test_cnt;
    int         test_err0;

    scan2x_top i_scan2x_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .base_pxl (base_pxl),
        .hs       (hs),
        .x2_pxl   (x2_pxl),
        .x2_hs    (x2_hs),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // pxl2_cen one cycle in four and pxl_cen on every other pxl2_cen
    always @(negedge clk) begin
        pxl2_cen = (cyc % 4 == 0);
        pxl_cen  = (cyc % 8 == 0);
    end

    // values seen by the DUT on the pxl2_cen edge
    always @(posedge clk) begin
        if (pxl2_cen) begin
            smp_rise = x2_hs && !smp_hs;
            smp_hs   = x2_hs;
            smp_pxl  = x2_pxl;
            -> sample_ev;
        end
    end

    task automatic compare_pixel(input string what, input pixel_t exp, input pixel_t act);
        chk_cnt++;
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_word(input string what, input wb_data_t exp, input wb_data_t act);
        chk_cnt++;
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_count(input string what, input int exp, input int act);
        chk_cnt++;
        if (exp != act) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    // one request that counts the cycles to ack and every ack it gets
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             input logic [3:0] sel, output wb_data_t rdat);
        int lat;
        int acks;
        lat  = 0;
        acks = 0;
        rdat = '0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        do begin
            @(negedge clk);
            lat++;
        end while (!wb_ack && lat < 8);
        if (wb_ack) begin
            acks = 1;
            rdat = wb_dat_r;
        end
        // strobe held one more cycle while ack has to drop
        @(negedge clk);
        if (wb_ack) begin
            acks++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // a second ack here would be a duplicate
        repeat (2) begin
            @(negedge clk);
            if (wb_ack) begin
                acks++;
            end
        end
        if (acks == 0) begin
            $display("%s: the bus slave gave no acknowledge within 8 cycles", cur_test);
            err_cnt++;
        end else begin
            compare_count("ack latency", 1, lat);
            compare_count("acks per access", 1, acks);
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat, input logic [3:0] sel);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, sel, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        bus_cycle(1'b0, adr, '0, 4'hf, dat);
    endtask

    task automatic set_modes(input int sl, input int hz);
        wb_write(csr_ctrl_addr, wb_data_t'(hz * 4 + sl), 4'h1);
        mode_sl = sl;
        mode_hz = hz;
    endtask

    // expected output from the mode rules per channel
    function automatic pixel_t expect_pixel(input pixel_t cur, input pixel_t prev,
                                            input bit second);
        pixel_t res;
        int     a;
        int     b;
        int     v;
        for (int c = 0; c < pixel_w / color_w; c++) begin
            a = int'(cur[c*color_w +: color_w]);
            b = int'(prev[c*color_w +: color_w]);
            case (mode_hz)
                1:       v = (a + b) / 2;
                2:       v = 0;
                default: v = a;
            endcase
            // second copy is the scan line
            if (second) begin
                case (mode_sl)
                    1:       v = v / 2;
                    2:       v = v / 4;
                    3:       v = 0;
                    default: v = v;
                endcase
            end
            res[c*color_w +: color_w] = color_t'(v);
        end
        return res;
    endfunction

    // n back to back lines with hs high for the first hs_w pixels
    task automatic send_lines(input int len, input int hs_w, input int n);
        for (int l = 0; l < n; l++) begin
            for (int i = 0; i < len; i++) begin
                do begin
                    @(negedge clk);
                end while (cyc % 8 != 0);
                base_pxl = pixel_t'($random(seed));
                hs       = (i < hs_w);
                ref_pix[l % 4][i] = base_pxl;
            end
        end
        hs = 1'b0;
    endtask

    // line l comes out while line l + 1 goes in
    // line 0 only primes the buffer
    task automatic check_lines(input int len, input int hs_w, input int n);
        pixel_t exp;
        pixel_t prev;
        int     sel;
        int     k;
        int     hi_a;
        int     hi_b;
        int     rises;
        // at the start of line 2 the read side switches to line 1
        repeat (3) @(posedge hs);
        @(sample_ev);
        for (int i = 0; i < n; i++) begin
            sel   = (i + 1) % 4;
            hi_a  = 0;
            hi_b  = 0;
            rises = 0;
            for (int j = 0; j < 2 * len; j++) begin
                @(sample_ev);
                if (j == 0) begin
                    compare_count("x2_hs rise at first pixel", 1, int'(smp_rise));
                end
                k = j % len;
                if (k == 0) begin
                    prev = '0;
                end else begin
                    prev = ref_pix[sel][k-1];
                end
                exp = expect_pixel(ref_pix[sel][k], prev, j >= len);
                compare_pixel("x2_pxl", exp, smp_pxl);
                if (smp_hs) begin
                    if (j < len) begin
                        hi_a++;
                    end else begin
                        hi_b++;
                    end
                end
                if (smp_rise) begin
                    rises++;
                end
            end
            compare_count("x2_hs rises per input line", 2, rises);
            compare_count("first x2_hs pulse width", hs_w, hi_a);
            compare_count("second x2_hs pulse width", hs_w, hi_b);
        end
    endtask

    task automatic run_lines(input int len, input int hs_w, input int n);
        fork
            send_lines(len, hs_w, n + 2);
            check_lines(len, hs_w, n);
        join
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = err_cnt;
        test_cnt++;
    endtask

    task automatic finish_test();
        $display("%s finished, %0d errors", cur_test, err_cnt - test_err0);
    endtask

    task automatic test_registers();
        wb_data_t rd;
        start_test("registers");
        wb_read(csr_ctrl_addr, rd);
        compare_word("ctrl after reset", 32'h0, rd);
        wb_read(csr_hlen_addr, rd);
        compare_word("hlen after reset", 32'h0, rd);
        wb_write(csr_ctrl_addr, 32'h0000_000b, 4'hf);
        wb_read(csr_ctrl_addr, rd);
        compare_word("ctrl readback", 32'h0000_000b, rd);
        // only bits 3:0 are stored
        wb_write(csr_ctrl_addr, 32'hffff_fff6, 4'hf);
        wb_read(csr_ctrl_addr, rd);
        compare_word("ctrl upper bits", 32'h0000_0006, rd);
        // byte lane 0 not selected
        wb_write(csr_ctrl_addr, 32'h0000_0001, 4'he);
        wb_read(csr_ctrl_addr, rd);
        compare_word("ctrl without lane 0", 32'h0000_0006, rd);
        wb_read(wb_addr_t'(7), rd);
        compare_word("unmapped word", 32'h0, rd);
        set_modes(0, 0);
        finish_test();
    endtask

    task automatic test_plain_doubling();
        start_test("plain_doubling");
        set_modes(0, 0);
        run_lines(40, 6, 2);
        finish_test();
    endtask

    task automatic test_scanlines();
        start_test("scanlines");
        for (int sl = 1; sl < 4; sl++) begin
            set_modes(sl, 0);
            run_lines(24, 3, 1);
        end
        finish_test();
    endtask

    task automatic test_blending();
        start_test("blending");
        set_modes(0, 1);
        run_lines(32, 8, 1);
        // blank wins over any dimming
        set_modes(1, 2);
        run_lines(32, 8, 1);
        finish_test();
    endtask

    task automatic test_sync_length();
        wb_data_t rd;
        start_test("sync_length");
        set_modes(0, 0);
        run_lines(50, 11, 1);
        wb_read(csr_hlen_addr, rd);
        compare_word("hlen", 32'd50, rd);
        finish_test();
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog timeout, the tests did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        pxl_cen  = 1'b0;
        pxl2_cen = 1'b0;
        base_pxl = '0;
        hs       = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        smp_pxl  = '0;
        smp_hs   = 1'b0;
        smp_rise = 1'b0;
        seed     = 32'hd0797ebb;
        mode_sl  = 0;
        mode_hz  = 0;
        err_cnt  = 0;
        chk_cnt  = 0;
        test_cnt = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        test_registers();
        test_plain_doubling();
        test_scanlines();
        test_blending();
        test_sync_length();
        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: video_pkg.sv
/*
 * Video path definitions for the scan doubler.
 * Pixel and colour widths, line buffer addressing and the two
 * display mode encodings written by the CSR block.
 * Import inside a module body; use scoped names in port lists.
 */
package video_pkg;

    // bits per colour channel
    localparam int color_w = 4;
    // red, green, blue
    localparam int color_n = 3;
    // red in the top bits, blue in the bottom bits
    localparam int pixel_w = color_n * color_w;
    // one line holds up to 512 pixels
    localparam int line_aw = 9;

    typedef logic [color_w-1:0] color_t;
    typedef logic [pixel_w-1:0] pixel_t;
    // pixel position, also used for the measured line length
    typedef logic [line_aw-1:0] line_addr_t;

    // dimming applied to the second copy of each line
    typedef enum logic [1:0] {
        sl_off   = 2'd0,
        sl_dim2  = 2'd1,
        sl_dim4  = 2'd2,
        sl_black = 2'd3
    } sl_mode_e;

    // horizontal treatment, code 3 acts like hz_off
    typedef enum logic [1:0] {
        hz_off   = 2'd0,
        hz_blend = 2'd1,
        hz_blank = 2'd2
    } hz_mode_e;

endpackage

// File: vlog.f
video_pkg.sv
scan_csr_pkg.sv
line_buffer.sv
scan_shade.sv
scan_doubler.sv
scan_csr.sv
scan2x_top.sv
tb_scan2x.sv
